/* soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// ==================================================
// Bus widths and sizes
// ==================================================
`define SOC_ADDR_W      32
`define SOC_DATA_W      32

`define SOC_DMEM_WORDS  256
`define SOC_GPIO_PINS   24

// ==================================================
// Memory map
// ==================================================
// Window sizes are given as the number of offset address bits
`define SOC_DMEM_BASE   32'h2000_0000
`define SOC_DMEM_AW     10
`define SOC_GPIO_BASE   32'h8000_0100
`define SOC_GPIO_AW     4
`define SOC_TIMER_BASE  32'h8000_0200
`define SOC_TIMER_AW    4

`endif

/* soc_pkg.sv */
`include "soc_settings.svh"

package soc_pkg;

    // Host operations, the stores come last
    typedef enum logic [2:0] {
        LB, LH, LW, LBU, LHU,
        SB, SH, SW
    } mem_op_e;

    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] addr;
        logic [`SOC_DATA_W-1:0] wdata;
        mem_op_e                op;
    } host_req_t;

    typedef struct packed {
        logic [`SOC_DATA_W-1:0] rdata;
        logic                   err;
    } host_rsp_t;

    typedef struct packed {
        logic [`SOC_ADDR_W-1:0]   adr;
        logic [`SOC_DATA_W-1:0]   dat;
        logic [`SOC_DATA_W/8-1:0] sel;
        logic                     we;
        logic                     stb;
    } wb_req_t;

    typedef struct packed {
        logic [`SOC_DATA_W-1:0] dat;
        logic                   ack;
        logic                   err;
    } wb_rsp_t;

    typedef enum logic [1:0] {SEL_DMEM, SEL_GPIO, SEL_TIMER, SEL_NONE} slave_sel_e;

    typedef enum logic {IDLE, WAIT_ACK} master_state_e;

    // Byte lane merge for register writes
    function automatic logic [`SOC_DATA_W-1:0] wb_merge(
        input logic [`SOC_DATA_W-1:0]   old_val,
        input logic [`SOC_DATA_W-1:0]   new_val,
        input logic [`SOC_DATA_W/8-1:0] sel
    );
        logic [`SOC_DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < `SOC_DATA_W/8; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

/* bus_master.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_master (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               req_valid_i,
    input  soc_pkg::host_req_t req_i,
    output logic               stall_o,
    output logic               rsp_valid_o,
    output soc_pkg::host_rsp_t rsp_o,
    output soc_pkg::wb_req_t   wb_o,
    input  soc_pkg::wb_rsp_t   wb_i
);
    import soc_pkg::*;

    localparam int AW = `SOC_ADDR_W;
    localparam int DW = `SOC_DATA_W;
    localparam int BW = DW / 8;

    master_state_e state_q;
    logic          accept;
    logic          done;

    // Bus cycle fields, held stable while stb is high
    logic [AW-1:0] adr_q;
    logic [DW-1:0] dat_q;
    logic [BW-1:0] sel_q;
    logic          we_q;
    logic          stb_q;
    mem_op_e       op_q;
    logic [1:0]    off_q;

    logic [DW-1:0] rdata_q;
    logic          err_q;
    logic          rsp_valid_q;

    // Byte select from operation and low address bits
    function automatic logic [BW-1:0] lane_sel(input mem_op_e op, input logic [1:0] off);
        logic [BW-1:0] s;
        case (op)
            SB:      s = 4'b0001 << off;
            SH:      s = off[1] ? 4'b1100 : 4'b0011;
            default: s = 4'b1111;
        endcase
        return s;
    endfunction

    // Replicate store data into every lane it may land on
    function automatic logic [DW-1:0] lane_data(input mem_op_e op, input logic [DW-1:0] wdata);
        logic [DW-1:0] d;
        case (op)
            SB:      d = {4{wdata[7:0]}};
            SH:      d = {2{wdata[15:0]}};
            default: d = wdata;
        endcase
        return d;
    endfunction

    // Extract and extend the addressed byte or halfword
    function automatic logic [DW-1:0] load_fmt(input mem_op_e op, input logic [1:0] off,
                                               input logic [DW-1:0] word);
        logic [DW-1:0] shifted;
        logic [DW-1:0] res;
        shifted = word >> {off, 3'b000};
        case (op)
            LB:      res = {{24{shifted[7]}}, shifted[7:0]};
            LBU:     res = {24'd0, shifted[7:0]};
            LH:      res = {{16{shifted[15]}}, shifted[15:0]};
            LHU:     res = {16'd0, shifted[15:0]};
            default: res = word;
        endcase
        return res;
    endfunction

    assign accept = req_valid_i & (state_q == IDLE);
    assign done   = wb_i.ack | wb_i.err;

    // ==================================================
    // Transfer FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            stb_q       <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= WAIT_ACK;
                        stb_q   <= 1'b1;
                    end
                end
                WAIT_ACK: begin
                    // Ack or err ends the cycle
                    if (done) begin
                        state_q     <= IDLE;
                        stb_q       <= 1'b0;
                        rsp_valid_q <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q <= {req_i.addr[AW-1:2], 2'b00};
            dat_q <= lane_data(req_i.op, req_i.wdata);
            sel_q <= lane_sel(req_i.op, req_i.addr[1:0]);
            we_q  <= req_i.op inside {SB, SH, SW};
            op_q  <= req_i.op;
            off_q <= req_i.addr[1:0];
        end
        if ((state_q == WAIT_ACK) && done) begin
            // Stores and errors return zero data
            rdata_q <= (wb_i.err || we_q) ? '0 : load_fmt(op_q, off_q, wb_i.dat);
            err_q   <= wb_i.err;
        end
    end

    assign stall_o     = (state_q == WAIT_ACK);
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = '{rdata: rdata_q, err: err_q};
    assign wb_o        = '{adr: adr_q, dat: dat_q, sel: sel_q, we: we_q, stb: stb_q};

endmodule

/* bus_intercon.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_intercon (
    input  logic             clk,
    input  logic             rst_n_i,
    input  soc_pkg::wb_req_t m_i,
    output soc_pkg::wb_rsp_t m_o,
    output soc_pkg::wb_req_t dmem_o,
    output soc_pkg::wb_req_t gpio_o,
    output soc_pkg::wb_req_t timer_o,
    input  soc_pkg::wb_rsp_t dmem_i,
    input  soc_pkg::wb_rsp_t gpio_i,
    input  soc_pkg::wb_rsp_t timer_i
);
    import soc_pkg::*;

    localparam int            AW         = `SOC_ADDR_W;
    localparam logic [AW-1:0] DMEM_BASE  = `SOC_DMEM_BASE;
    localparam logic [AW-1:0] GPIO_BASE  = `SOC_GPIO_BASE;
    localparam logic [AW-1:0] TIMER_BASE = `SOC_TIMER_BASE;

    slave_sel_e sel;
    logic       err_q;

    // Address decode, compare only the bits above each window
    always_comb begin
        if (m_i.adr[AW-1:`SOC_DMEM_AW] == DMEM_BASE[AW-1:`SOC_DMEM_AW]) begin
            sel = SEL_DMEM;
        end else if (m_i.adr[AW-1:`SOC_GPIO_AW] == GPIO_BASE[AW-1:`SOC_GPIO_AW]) begin
            sel = SEL_GPIO;
        end else if (m_i.adr[AW-1:`SOC_TIMER_AW] == TIMER_BASE[AW-1:`SOC_TIMER_AW]) begin
            sel = SEL_TIMER;
        end else begin
            sel = SEL_NONE;
        end
    end

    // Strobe only reaches the selected slave
    always_comb begin
        dmem_o      = m_i;
        gpio_o      = m_i;
        timer_o     = m_i;
        dmem_o.stb  = m_i.stb & (sel == SEL_DMEM);
        gpio_o.stb  = m_i.stb & (sel == SEL_GPIO);
        timer_o.stb = m_i.stb & (sel == SEL_TIMER);
    end

    // ==================================================
    // Error response for unmapped addresses
    // ==================================================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= m_i.stb & (sel == SEL_NONE) & ~err_q;
        end
    end

    always_comb begin
        case (sel)
            SEL_DMEM:  m_o = dmem_i;
            SEL_GPIO:  m_o = gpio_i;
            SEL_TIMER: m_o = timer_i;
            default:   m_o = '{dat: '0, ack: 1'b0, err: err_q};
        endcase
    end

endmodule

/* data_ram.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module data_ram (
    input  logic             clk,
    input  logic             rst_n_i,
    input  soc_pkg::wb_req_t wb_i,
    output soc_pkg::wb_rsp_t wb_o
);
    localparam int DW    = `SOC_DATA_W;
    localparam int IDX_W = $clog2(`SOC_DMEM_WORDS);

    logic [DW-1:0]    mem [`SOC_DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [DW-1:0]    rdata_q;
    logic             ack_q;
    logic             req;

    // Word offset within the window
    assign idx = wb_i.adr[IDX_W+1:2];
    assign req = wb_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (req) begin
            if (wb_i.we) begin
                for (int i = 0; i < DW/8; i++) begin
                    if (wb_i.sel[i]) begin
                        mem[idx][8*i +: 8] <= wb_i.dat[8*i +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    // One cycle ack pulse
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    assign wb_o = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

/* gpio_regs.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module gpio_regs (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  soc_pkg::wb_req_t          wb_i,
    output soc_pkg::wb_rsp_t          wb_o,
    input  logic [`SOC_GPIO_PINS-1:0] gpio_i,
    output logic [`SOC_GPIO_PINS-1:0] gpio_o,
    output logic [`SOC_GPIO_PINS-1:0] gpio_oe_o
);
    import soc_pkg::*;

    localparam int DW = `SOC_DATA_W;
    localparam int NP = `SOC_GPIO_PINS;

    logic [NP-1:0] out_q;
    logic [NP-1:0] oe_q;
    logic [NP-1:0] sync1_q;
    logic [NP-1:0] sync2_q;
    logic [DW-1:0] rdata_q;
    logic          ack_q;
    logic          req;
    logic [1:0]    reg_idx;
    logic [DW-1:0] out_wr;
    logic [DW-1:0] oe_wr;

    // 0 OUT, 1 OE, 2 IN
    assign reg_idx = wb_i.adr[`SOC_GPIO_AW-1:2];
    assign req     = wb_i.stb & ~ack_q;
    assign out_wr  = wb_merge(DW'(out_q), wb_i.dat, wb_i.sel);
    assign oe_wr   = wb_merge(DW'(oe_q), wb_i.dat, wb_i.sel);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q   <= '0;
            oe_q    <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            // Two flop input synchronizer
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            ack_q   <= req;
            if (req && wb_i.we) begin
                case (reg_idx)
                    2'd0:    out_q <= out_wr[NP-1:0];
                    2'd1:    oe_q  <= oe_wr[NP-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Upper bits read as zero
    always_ff @(posedge clk) begin
        if (req) begin
            case (reg_idx)
                2'd0:    rdata_q <= DW'(out_q);
                2'd1:    rdata_q <= DW'(oe_q);
                2'd2:    rdata_q <= DW'(sync2_q);
                default: rdata_q <= '0;
            endcase
        end
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = oe_q;
    assign wb_o      = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

/* mtimer.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module mtimer (
    input  logic             clk,
    input  logic             rst_n_i,
    input  soc_pkg::wb_req_t wb_i,
    output soc_pkg::wb_rsp_t wb_o,
    output logic             timer_irq_o
);
    import soc_pkg::*;

    localparam int DW = `SOC_DATA_W;

    logic [63:0]   mtime_q;
    logic [63:0]   mtimecmp_q;
    logic          irq_q;
    logic [DW-1:0] rdata_q;
    logic          ack_q;
    logic          req;
    logic          wr;
    logic [1:0]    reg_idx;
    logic [DW-1:0] cur_word;
    logic [DW-1:0] wr_word;

    // 0 mtime lo, 1 mtime hi, 2 mtimecmp lo, 3 mtimecmp hi
    assign reg_idx = wb_i.adr[`SOC_TIMER_AW-1:2];
    assign req     = wb_i.stb & ~ack_q;
    assign wr      = req & wb_i.we;

    always_comb begin
        case (reg_idx)
            2'd0:    cur_word = mtime_q[31:0];
            2'd1:    cur_word = mtime_q[63:32];
            2'd2:    cur_word = mtimecmp_q[31:0];
            default: cur_word = mtimecmp_q[63:32];
        endcase
    end

    assign wr_word = wb_merge(cur_word, wb_i.dat, wb_i.sel);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            irq_q      <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            ack_q <= req;
            irq_q <= (mtime_q >= mtimecmp_q);
            // A bus write to mtime takes priority over the count
            if (wr && (reg_idx == 2'd0)) begin
                mtime_q <= {mtime_q[63:32], wr_word};
            end else if (wr && (reg_idx == 2'd1)) begin
                mtime_q <= {wr_word, mtime_q[31:0]};
            end else begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr && (reg_idx == 2'd2)) begin
                mtimecmp_q <= {mtimecmp_q[63:32], wr_word};
            end else if (wr && (reg_idx == 2'd3)) begin
                mtimecmp_q <= {wr_word, mtimecmp_q[31:0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdata_q <= cur_word;
        end
    end

    assign timer_irq_o = irq_q;
    assign wb_o        = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

/* soc_fabric.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_fabric (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      req_valid_i,
    input  soc_pkg::host_req_t        req_i,
    output logic                      stall_o,
    output logic                      rsp_valid_o,
    output soc_pkg::host_rsp_t        rsp_o,
    input  logic [`SOC_GPIO_PINS-1:0] gpio_i,
    output logic [`SOC_GPIO_PINS-1:0] gpio_o,
    output logic [`SOC_GPIO_PINS-1:0] gpio_oe_o,
    output logic                      timer_irq_o
);
    import soc_pkg::*;

    // Master side
    wb_req_t m_req;
    wb_rsp_t m_rsp;

    // Slave side
    wb_req_t dmem_req;
    wb_rsp_t dmem_rsp;
    wb_req_t gpio_req;
    wb_rsp_t gpio_rsp;
    wb_req_t timer_req;
    wb_rsp_t timer_rsp;

    bus_master u_master (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .stall_o     (stall_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .wb_o        (m_req),
        .wb_i        (m_rsp)
    );

    bus_intercon u_intercon (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .m_i     (m_req),
        .m_o     (m_rsp),
        .dmem_o  (dmem_req),
        .gpio_o  (gpio_req),
        .timer_o (timer_req),
        .dmem_i  (dmem_rsp),
        .gpio_i  (gpio_rsp),
        .timer_i (timer_rsp)
    );

    data_ram u_dmem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (dmem_req),
        .wb_o    (dmem_rsp)
    );

    gpio_regs u_gpio (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_i      (gpio_req),
        .wb_o      (gpio_rsp),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

    mtimer u_timer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_i        (timer_req),
        .wb_o        (timer_rsp),
        .timer_irq_o (timer_irq_o)
    );

endmodule

/* soc_fabric_chk.sv */
`timescale 1ns/1ps

module soc_fabric_chk (
    input logic clk,
    input logic rst_n_i,
    input logic req_valid_i,
    input logic stall_i,
    input logic rsp_valid_i,
    input logic stb_i,
    input logic ack_i,
    input logic err_i
);
    int violations = 0;

    // Host side quiet right after reset release
    a_reset_idle: assert property (@(posedge clk) $rose(rst_n_i) |-> !stall_i && !rsp_valid_i)
    else begin
        $error("stall or rsp_valid high after reset");
        violations++;
    end

    // Strobe held until the cycle ends
    a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        stb_i && !ack_i && !err_i |=> stb_i)
    else begin
        $error("master stb dropped before ack or err");
        violations++;
    end

    a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_i |=> !rsp_valid_i)
    else begin
        $error("rsp_valid high for two cycles");
        violations++;
    end

    // ==================================================
    // Accept to response latency of 3 edges
    // ==================================================
    a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_valid_i && !stall_i |=> !rsp_valid_i ##1 !rsp_valid_i ##1 rsp_valid_i)
    else begin
        $error("rsp_valid not 3 edges after acceptance");
        violations++;
    end

endmodule

bind soc_fabric soc_fabric_chk u_chk (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .stall_i     (stall_o),
    .rsp_valid_i (rsp_valid_o),
    .stb_i       (m_req.stb),
    .ack_i       (m_rsp.ack),
    .err_i       (m_rsp.err)
);

/* soc_fabric_tb.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_fabric_tb;
    import soc_pkg::*;

    localparam int          CLK_PERIOD  = 40;
    localparam int          NP          = `SOC_GPIO_PINS;
    localparam int          RAM_WORDS   = 16;
    localparam int          ACCESSES    = 2 * RAM_WORDS + 25 + 5 + 6 + 4 + 5;
    localparam int          WDOG_CYCLES = ACCESSES * 10 + 2000;
    localparam int          RSP_TIMEOUT = 20;
    localparam logic [31:0] DMEM        = `SOC_DMEM_BASE;
    localparam logic [31:0] GPIO        = `SOC_GPIO_BASE;
    localparam logic [31:0] TIMER       = `SOC_TIMER_BASE;

    logic          clk;
    logic          rst_n_i;
    logic          req_valid_i;
    host_req_t     req_i;
    logic          stall_o;
    logic          rsp_valid_o;
    host_rsp_t     rsp_o;
    logic [NP-1:0] gpio_i;
    logic [NP-1:0] gpio_o;
    logic [NP-1:0] gpio_oe_o;
    logic          timer_irq_o;

    // Reference copy of the data RAM, word indexed
    logic [31:0] ram_model [`SOC_DMEM_WORDS];
    int          data_errs;
    int          err_errs;
    int          pin_errs;
    int          flag_errs;
    int          other_errs;
    int          total_errs;
    int unsigned seed_val;

    soc_fabric DUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .stall_o     (stall_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .gpio_oe_o   (gpio_oe_o),
        .timer_irq_o (timer_irq_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_data(input host_rsp_t rsp, input logic [`SOC_DATA_W-1:0] exp,
                              input string what);
        if (rsp.rdata !== exp) begin
            $display("Error at %0d ns: rsp_o.rdata for %s expected 0x%08h, got 0x%08h",
                     $time, what, exp, rsp.rdata);
            data_errs++;
        end
    endtask

    task automatic check_err(input host_rsp_t rsp, input logic exp, input string what);
        if (rsp.err !== exp) begin
            $display("Error at %0d ns: rsp_o.err for %s expected %b, got %b",
                     $time, what, exp, rsp.err);
            err_errs++;
        end
    endtask

    task automatic check_gpio(input logic [NP-1:0] act, input logic [NP-1:0] exp,
                              input string what);
        if (act !== exp) begin
            $display("Error at %0d ns: %s expected 0x%06h, got 0x%06h", $time, what, exp, act);
            pin_errs++;
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            $display("Error at %0d ns: %s expected %b, got %b", $time, what, exp, act);
            flag_errs++;
        end
    endtask

    // ==================================================
    // Host port access
    // ==================================================
    task automatic drive_request(input mem_op_e op, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        req_valid_i <= 1'b1;
        req_i       <= '{addr: addr, wdata: wdata, op: op};
    endtask

    task automatic bus_access(input mem_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata, output host_rsp_t rsp);
        int waited;
        @(posedge clk);
        drive_request(op, addr, wdata);
        // Accepting edge
        @(posedge clk);
        req_valid_i <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!rsp_valid_o && waited < RSP_TIMEOUT);
        if (!rsp_valid_o) begin
            $display("No response arrived for %s at address 0x%08h", op.name(), addr);
            other_errs++;
        end
        rsp = rsp_o;
    endtask

    task automatic store_and_ack(input mem_op_e op, input logic [31:0] addr,
                                 input logic [31:0] wdata, input string what);
        host_rsp_t rsp;
        bus_access(op, addr, wdata, rsp);
        check_err(rsp, 1'b0, what);
    endtask

    task automatic load_and_compare(input mem_op_e op, input logic [31:0] addr,
                                    input logic [31:0] exp, input string what);
        host_rsp_t rsp;
        bus_access(op, addr, '0, rsp);
        check_err(rsp, 1'b0, what);
        check_data(rsp, exp, what);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic ram_round_trip();
        int          idx [RAM_WORDS];
        logic [31:0] data;
        for (int i = 0; i < RAM_WORDS; i++) begin
            idx[i] = $urandom_range(`SOC_DMEM_WORDS - 1);
            data   = $urandom;
            ram_model[idx[i]] = data;
            store_and_ack(SW, DMEM + 32'(idx[i] * 4), data, "RAM SW");
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            load_and_compare(LW, DMEM + 32'(idx[i] * 4), ram_model[idx[i]], "RAM LW");
        end
    endtask

    task automatic subword_access();
        int          idx;
        logic [31:0] addr;
        logic [7:0]  b;
        logic [15:0] h;
        idx  = $urandom_range(`SOC_DMEM_WORDS - 1);
        addr = DMEM + 32'(idx * 4);
        ram_model[idx] = $urandom;
        store_and_ack(SW, addr, ram_model[idx], "base SW");
        for (int lane = 0; lane < 4; lane++) begin
            // Even lanes negative, odd lanes positive
            b    = 8'($urandom);
            b[7] = (lane % 2 == 0);
            ram_model[idx][8*lane +: 8] = b;
            store_and_ack(SB, addr + 32'(lane), {24'($urandom), b}, "SB");
            load_and_compare(LW, addr, ram_model[idx], "LW after SB");
            load_and_compare(LB, addr + 32'(lane), {{24{b[7]}}, b}, "LB");
            load_and_compare(LBU, addr + 32'(lane), {24'd0, b}, "LBU");
        end
        for (int half = 0; half < 2; half++) begin
            h     = 16'($urandom);
            h[15] = (half == 0);
            ram_model[idx][16*half +: 16] = h;
            store_and_ack(SH, addr + 32'(2 * half), {16'($urandom), h}, "SH");
            load_and_compare(LW, addr, ram_model[idx], "LW after SH");
            load_and_compare(LH, addr + 32'(2 * half), {{16{h[15]}}, h}, "LH");
            load_and_compare(LHU, addr + 32'(2 * half), {16'd0, h}, "LHU");
        end
    endtask

    task automatic gpio_pins();
        logic [31:0]   out_val;
        logic [31:0]   oe_val;
        logic [7:0]    b;
        logic [NP-1:0] pins;
        out_val = $urandom;
        store_and_ack(SW, GPIO, out_val, "GPIO OUT write");
        check_gpio(gpio_o, out_val[NP-1:0], "gpio_o");
        load_and_compare(LW, GPIO, 32'(out_val[NP-1:0]), "GPIO OUT read");
        oe_val = $urandom;
        store_and_ack(SW, GPIO + 32'h4, oe_val, "GPIO OE write");
        check_gpio(gpio_oe_o, oe_val[NP-1:0], "gpio_oe_o");
        // Byte write into lane 2 of OE
        b = 8'($urandom);
        oe_val[23:16] = b;
        store_and_ack(SB, GPIO + 32'h6, {24'd0, b}, "GPIO OE byte write");
        check_gpio(gpio_oe_o, oe_val[NP-1:0], "gpio_oe_o after SB");
        check_gpio(gpio_o, out_val[NP-1:0], "gpio_o after OE writes");
        pins = NP'($urandom);
        @(posedge clk);
        gpio_i <= pins;
        repeat (3) @(posedge clk);
        load_and_compare(LW, GPIO + 32'h8, 32'(pins), "GPIO IN read");
    endtask

    task automatic timer_compare();
        host_rsp_t   rsp;
        logic [31:0] t0;
        logic [31:0] t1;
        int          waited;
        bus_access(LW, TIMER, '0, rsp);
        check_err(rsp, 1'b0, "mtime low read");
        t0 = rsp.rdata;
        bus_access(LW, TIMER, '0, rsp);
        check_err(rsp, 1'b0, "mtime low read");
        t1 = rsp.rdata;
        if (t1 <= t0) begin
            $display("Error at %0d ns: rsp_o.rdata for mtime low expected above 0x%08h, got 0x%08h",
                     $time, t0, t1);
            data_errs++;
        end
        store_and_ack(SW, TIMER + 32'hC, 32'h0, "mtimecmp high write");
        store_and_ack(SW, TIMER + 32'h8, t1 + 32'd100, "mtimecmp low write");
        check_flag(timer_irq_o, 1'b0, "timer_irq_o before compare");
        waited = 0;
        while (!timer_irq_o && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if (!timer_irq_o) begin
            $display("Timer interrupt did not rise after mtime passed mtimecmp");
            other_errs++;
        end
        store_and_ack(SW, TIMER + 32'h8, 32'hFFFF_FFFF, "mtimecmp low restore");
        store_and_ack(SW, TIMER + 32'hC, 32'hFFFF_FFFF, "mtimecmp high restore");
        check_flag(timer_irq_o, 1'b0, "timer_irq_o after restore");
    endtask

    task automatic unmapped_access();
        host_rsp_t   rsp;
        logic [31:0] val;
        val = $urandom;
        ram_model[5] = val;
        store_and_ack(SW, DMEM + 32'h14, val, "RAM SW before unmapped");
        // Just past the RAM window
        bus_access(LW, DMEM + 32'h400, '0, rsp);
        check_err(rsp, 1'b1, "unmapped LW");
        check_data(rsp, '0, "unmapped LW");
        // Just past the GPIO window
        bus_access(SW, GPIO + 32'h10, $urandom, rsp);
        check_err(rsp, 1'b1, "unmapped SW");
        check_data(rsp, '0, "unmapped SW");
        load_and_compare(LW, DMEM + 32'h14, ram_model[5], "RAM LW after unmapped");
    endtask

    task automatic stalled_request();
        logic [31:0] first;
        int          responses;
        first = $urandom;
        ram_model[9]  = $urandom;
        ram_model[10] = $urandom;
        store_and_ack(SW, DMEM + 32'h24, ram_model[9], "RAM SW before stall");
        store_and_ack(SW, DMEM + 32'h28, ram_model[10], "RAM SW before stall");
        @(posedge clk);
        drive_request(SW, DMEM + 32'h24, first);
        @(posedge clk);
        // Second store shows up while the first is in flight
        drive_request(SW, DMEM + 32'h28, ~first);
        @(negedge clk);
        check_flag(stall_o, 1'b1, "stall_o during transfer");
        @(posedge clk);
        @(posedge clk);
        req_valid_i <= 1'b0;
        responses = 0;
        repeat (12) begin
            @(negedge clk);
            if (rsp_valid_o) begin
                responses++;
            end
        end
        if (responses != 1) begin
            $display("Error at %0d ns: response count expected 1, got %0d", $time, responses);
            other_errs++;
        end
        ram_model[9] = first;
        load_and_compare(LW, DMEM + 32'h24, ram_model[9], "LW of accepted store");
        load_and_compare(LW, DMEM + 32'h28, ram_model[10], "LW of ignored store");
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        gpio_i      = '0;
        data_errs   = 0;
        err_errs    = 0;
        pin_errs    = 0;
        flag_errs   = 0;
        other_errs  = 0;
        seed_val    = $urandom(32'h52ac_f6ee);
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_flag(stall_o, 1'b0, "stall_o after reset");
        check_flag(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
        check_flag(timer_irq_o, 1'b0, "timer_irq_o after reset");
        check_gpio(gpio_o, '0, "gpio_o after reset");
        check_gpio(gpio_oe_o, '0, "gpio_oe_o after reset");
        ram_round_trip();
        subword_access();
        gpio_pins();
        timer_compare();
        unmapped_access();
        stalled_request();
        repeat (4) @(posedge clk);
        total_errs = data_errs + err_errs + pin_errs + flag_errs + other_errs
                   + DUT.u_chk.violations;
        $display("Errors %0d: data %0d, err %0d, pin %0d, flag %0d, other %0d, assert %0d",
                 total_errs, data_errs, err_errs, pin_errs, flag_errs, other_errs,
                 DUT.u_chk.violations);
        if (total_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
soc_pkg.sv
bus_master.sv
bus_intercon.sv
data_ram.sv
gpio_regs.sv
mtimer.sv
soc_fabric.sv
soc_fabric_chk.sv
soc_fabric_tb.sv
